//--- hdl/core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Core widths, reset PC, RV32I opcodes and shared types
// ~~~~~~~~~~~~~~~~~~~~
package core_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;

    localparam word_t RESET_PC = 32'h8000_0000;

    // Major opcodes, inst[6:0]
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        REQ,   // Request on the fetch port
        WAIT,  // Waiting for the response
        EXEC
    } fetch_state_t;

endpackage

//--- hdl/decode_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// Decoded instruction fields
// ~~~~~~~~~~~~~~~~~~~~
interface decode_if import core_pkg::*; ();

    opcode_t   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
    inst_fmt_t fmt;
    alu_op_t   alu_op;

    modport dec (output opcode, funct3, rd, rs1, rs2, imm, fmt, alu_op);
    modport exe (input opcode, funct3, rd, rs1, rs2, imm, fmt, alu_op);

endinterface

//--- hdl/alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// RV32I integer ALU
// ~~~~~~~~~~~~~~~~~~~~
module alu import core_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- hdl/fetch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// PC, instruction register and fetch/execute FSM
// ~~~~~~~~~~~~~~~~~~~~
module fetch_unit import core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output logic  imem_req_valid,
    input  logic  imem_req_ready,
    output word_t imem_addr,
    input  logic  imem_resp_valid,
    input  word_t imem_resp_data,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t inst,
    output word_t pc,
    output word_t next_pc,
    output logic  exec_strobe
);

    fetch_state_t state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= REQ;
            pc    <= RESET_PC;
        end else begin
            unique case (state)
                REQ: begin
                    if (imem_req_ready) state <= WAIT;  // Request accepted
                end
                WAIT: begin
                    if (imem_resp_valid) state <= EXEC;
                end
                EXEC: begin
                    pc    <= next_pc;
                    state <= REQ;
                end
                default: state <= REQ;
            endcase
        end
    end

    // Instruction held for the whole EXEC cycle
    always_ff @(posedge clk) begin
        if (state == WAIT && imem_resp_valid) begin
            inst <= imem_resp_data;
        end
    end

    assign imem_req_valid = (state == REQ);
    assign imem_addr      = pc;
    assign exec_strobe    = (state == EXEC);
    assign next_pc        = jump_en ? jump_target : pc + 32'd4;

endmodule

//--- hdl/inst_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// RV32I field split, format, immediate and ALU op
// ~~~~~~~~~~~~~~~~~~~~
module inst_decoder import core_pkg::*; (
    input word_t  inst,
    decode_if.dec dec
);

    logic funct7_b5;

    assign dec.opcode = inst[6:0];
    assign dec.funct3 = inst[14:12];
    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];
    assign funct7_b5  = inst[30];

    always_comb begin
        unique case (dec.opcode)
            OPC_OP:               dec.fmt = FMT_R;
            OPC_OP_IMM, OPC_JALR: dec.fmt = FMT_I;
            OPC_LUI, OPC_AUIPC:   dec.fmt = FMT_U;
            OPC_JAL:              dec.fmt = FMT_J;
            OPC_BRANCH:           dec.fmt = FMT_B;
            default:              dec.fmt = FMT_NONE;
        endcase
    end

    // Sign-extended immediates
    always_comb begin
        unique case (dec.fmt)
            FMT_I:   dec.imm = {{20{inst[31]}}, inst[31:20]};
            FMT_S:   dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B:   dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U:   dec.imm = {inst[31:12], 12'b0};
            FMT_J:   dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: dec.imm = '0;
        endcase
    end

    always_comb begin
        dec.alu_op = ALU_ADD;  // Address and upper-immediate math
        if (dec.opcode == OPC_OP || dec.opcode == OPC_OP_IMM) begin
            unique case (dec.funct3)
                3'b000: begin
                    // ADDI has no SUB form
                    if (dec.opcode == OPC_OP && funct7_b5) dec.alu_op = ALU_SUB;
                end
                3'b001:  dec.alu_op = ALU_SLL;
                3'b010:  dec.alu_op = ALU_SLT;
                3'b011:  dec.alu_op = ALU_SLTU;
                3'b100:  dec.alu_op = ALU_XOR;
                3'b101:  dec.alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
                3'b110:  dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

//--- hdl/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// Integer register file, 2R1W
// ~~~~~~~~~~~~~~~~~~~~
module reg_file import core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    decode_if.exe dec,
    input  logic  wr_en,
    input  word_t wr_data,
    output word_t rdata1,
    output word_t rdata2
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && dec.rd != 5'd0) begin
            regs[dec.rd] <= wr_data;
        end
    end

    // x0 reads as zero
    assign rdata1 = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
    assign rdata2 = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

//--- hdl/exec_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Operand select, branch decision, jump target and write-back
// ~~~~~~~~~~~~~~~~~~~~
module exec_unit import core_pkg::*; (
    decode_if.exe dec,
    input  word_t rdata1,
    input  word_t rdata2,
    input  word_t pc,
    output logic  jump_en,
    output word_t jump_target,
    output logic  wb_en,
    output word_t wb_data
);

    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  is_jalr;
    logic  is_link;
    logic  taken;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    assign is_jalr = (dec.opcode == OPC_JALR);
    assign is_link = (dec.opcode == OPC_JAL) || is_jalr;

    always_comb begin
        unique case (dec.fmt)
            FMT_R: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            FMT_I: begin
                alu_a = rdata1;
                alu_b = dec.imm;
            end
            FMT_U: begin
                alu_a = (dec.opcode == OPC_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            FMT_B, FMT_J: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
        endcase
    end

    always_comb begin
        unique case (dec.funct3)
            3'b000:  taken = (rdata1 == rdata2);                   // BEQ
            3'b001:  taken = (rdata1 != rdata2);                   // BNE
            3'b100:  taken = ($signed(rdata1) < $signed(rdata2));  // BLT
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2)); // BGE
            3'b110:  taken = (rdata1 < rdata2);                    // BLTU
            3'b111:  taken = (rdata1 >= rdata2);                   // BGEU
            default: taken = 1'b0;
        endcase
    end

    assign jump_en     = is_link || (dec.fmt == FMT_B && taken);
    assign jump_target = is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

    assign wb_data = is_link ? pc + 32'd4 : alu_result;
    assign wb_en   = (dec.opcode == OPC_OP || dec.opcode == OPC_OP_IMM ||
                      dec.opcode == OPC_LUI || dec.opcode == OPC_AUIPC || is_link)
                     && dec.rd != 5'd0;

endmodule

//--- hdl/core_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Multicycle RV32I core top level
// ~~~~~~~~~~~~~~~~~~~~
module core_top import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output logic      imem_req_valid,
    input  logic      imem_req_ready,
    output word_t     imem_addr,
    input  logic      imem_resp_valid,
    input  word_t     imem_resp_data,
    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      retire_rd_we,
    output reg_addr_t retire_rd,
    output word_t     retire_rd_data,
    output word_t     retire_next_pc
);

    word_t inst;
    word_t pc;
    word_t next_pc;
    logic  exec_strobe;
    logic  jump_en;
    word_t jump_target;
    word_t rdata1;
    word_t rdata2;
    logic  wb_en;
    word_t wb_data;

    decode_if dec_bus ();

    fetch_unit u_fetch (
        .clk             (clk),
        .reset           (reset),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_addr       (imem_addr),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .jump_en         (jump_en),
        .jump_target     (jump_target),
        .inst            (inst),
        .pc              (pc),
        .next_pc         (next_pc),
        .exec_strobe     (exec_strobe)
    );

    inst_decoder u_dec (
        .inst (inst),
        .dec  (dec_bus.dec)
    );

    reg_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .dec     (dec_bus.exe),
        .wr_en   (exec_strobe && wb_en),  // Write only in EXEC
        .wr_data (wb_data),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    exec_unit u_exec (
        .dec         (dec_bus.exe),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .pc          (pc),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .wb_en       (wb_en),
        .wb_data     (wb_data)
    );

    assign retire_valid   = exec_strobe;
    assign retire_pc      = pc;
    assign retire_rd_we   = wb_en;
    assign retire_rd      = dec_bus.rd;
    assign retire_rd_data = wb_data;
    assign retire_next_pc = next_pc;

endmodule

//--- dv/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- dv/tb_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Core testbench with instruction table, fetch responder and retire checks
// ~~~~~~~~~~~~~~~~~~~~
module tb_core import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 50;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        logic      we;
        reg_addr_t rd;
        word_t     data;
        word_t     npc;
    } row_t;

    logic      clk;
    logic      reset;
    logic      imem_req_valid;
    logic      imem_req_ready;
    word_t     imem_addr;
    logic      imem_resp_valid;
    word_t     imem_resp_data;
    logic      retire_valid;
    word_t     retire_pc;
    logic      retire_rd_we;
    reg_addr_t retire_rd;
    word_t     retire_rd_data;
    word_t     retire_next_pc;

    row_t rows[$];
    int   row_errors;
    int   rows_passed;
    int   rows_failed;

    tb_clock_gen u_clk (.clk(clk), .reset(reset));

    core_top DUT (.*);

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2, rs1,
                                     input funct3_t f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input funct3_t f3, input reg_addr_t rd, input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Branch and jump offsets are given in half words
    function automatic word_t b_type(input logic [12:1] imm, input reg_addr_t rs2, rs1,
                                     input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:1] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Fetch address follows the previous row's next PC; rd of 0 means no write
    task automatic add_row(input word_t inst, input reg_addr_t rd, input word_t data,
                           input logic [15:0] npc_off);
        row_t r;
        r.pc   = (rows.size() == 0) ? RESET_PC : rows[$].npc;
        r.inst = inst;
        r.we   = (rd != 5'd0);
        r.rd   = rd;
        r.data = data;
        r.npc  = {RESET_PC[31:16], npc_off};
        rows.push_back(r);
    endtask

    task automatic load_table();
        // x1 = 5, x2 = -3
        add_row(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 5'd1, 32'd5, 16'h0004);
        add_row(i_type(12'hffd, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 5'd2, 32'hfffffffd, 16'h0008);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'd2, 16'h000c);
        add_row(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'd8, 16'h0010);
        add_row(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd5), 5'd5, 32'd1, 16'h0014);
        add_row(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd6), 5'd6, 32'd0, 16'h0018);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 5'd7, 32'hfffffff8, 16'h001c);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd8), 5'd8, 32'hfffffffd, 16'h0020);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd9), 5'd9, 32'd5, 16'h0024);
        add_row(r_type(7'h00, 5'd4, 5'd1, 3'b001, 5'd10), 5'd10, 32'h00000500, 16'h0028);
        add_row(r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd11), 5'd11, 32'h07ffffff, 16'h002c);
        add_row(r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd12), 5'd12, 32'hffffffff, 16'h0030);
        add_row(i_type(12'd1, 5'd2, 3'b010, 5'd13, OPC_OP_IMM), 5'd13, 32'd1, 16'h0034);
        add_row(i_type(12'hfff, 5'd1, 3'b011, 5'd14, OPC_OP_IMM), 5'd14, 32'd1, 16'h0038);
        add_row(i_type(12'h0ff, 5'd1, 3'b100, 5'd15, OPC_OP_IMM), 5'd15, 32'h000000fa, 16'h003c);
        add_row(i_type(12'h030, 5'd1, 3'b110, 5'd16, OPC_OP_IMM), 5'd16, 32'h00000035, 16'h0040);
        add_row(i_type(12'h0f0, 5'd2, 3'b111, 5'd17, OPC_OP_IMM), 5'd17, 32'h000000f0, 16'h0044);
        add_row(i_type(12'h004, 5'd1, 3'b001, 5'd18, OPC_OP_IMM), 5'd18, 32'h00000050, 16'h0048);
        add_row(i_type(12'h01c, 5'd2, 3'b101, 5'd19, OPC_OP_IMM), 5'd19, 32'h0000000f, 16'h004c);
        add_row(i_type(12'h401, 5'd2, 3'b101, 5'd20, OPC_OP_IMM), 5'd20, 32'hfffffffe, 16'h0050);
        add_row(u_type(20'h12345, 5'd21, OPC_LUI), 5'd21, 32'h12345000, 16'h0054);
        add_row(u_type(20'h00001, 5'd22, OPC_AUIPC), 5'd22, 32'h80001054, 16'h0058);
        add_row(i_type(12'd7, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 5'd0, 32'd0, 16'h005c);  // x0
        add_row(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd23), 5'd23, 32'd5, 16'h0060);
        // Branches, taken then not taken
        add_row(b_type(12'd4, 5'd9, 5'd1, 3'b000), 5'd0, 32'd0, 16'h0068);
        add_row(b_type(12'd4, 5'd2, 5'd1, 3'b000), 5'd0, 32'd0, 16'h006c);
        add_row(b_type(12'd4, 5'd2, 5'd1, 3'b001), 5'd0, 32'd0, 16'h0074);
        add_row(b_type(12'd4, 5'd9, 5'd1, 3'b001), 5'd0, 32'd0, 16'h0078);
        add_row(b_type(12'd4, 5'd1, 5'd2, 3'b100), 5'd0, 32'd0, 16'h0080);
        add_row(b_type(12'd4, 5'd2, 5'd1, 3'b100), 5'd0, 32'd0, 16'h0084);
        add_row(b_type(12'd4, 5'd2, 5'd1, 3'b101), 5'd0, 32'd0, 16'h008c);
        add_row(b_type(12'd4, 5'd1, 5'd2, 3'b101), 5'd0, 32'd0, 16'h0090);
        add_row(b_type(12'd4, 5'd2, 5'd1, 3'b110), 5'd0, 32'd0, 16'h0098);
        add_row(b_type(12'd4, 5'd1, 5'd2, 3'b110), 5'd0, 32'd0, 16'h009c);
        add_row(b_type(12'hff8, 5'd1, 5'd2, 3'b111), 5'd0, 32'd0, 16'h008c);  // Backward
        add_row(b_type(12'd4, 5'd2, 5'd1, 3'b111), 5'd0, 32'd0, 16'h0090);
        add_row(j_type(20'd8, 5'd24), 5'd24, 32'h80000094, 16'h00a0);
        add_row(i_type(12'hfad, 5'd22, 3'b000, 5'd25, OPC_JALR), 5'd25, 32'h800000a4, 16'h1000);
        add_row(32'h00000073, 5'd0, 32'd0, 16'h1004);  // Unsupported opcode
    endtask

    task automatic compare(input string field, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, field, got, exp);
            row_errors++;
        end
    endtask

    // Waits on falling edges until the chosen DUT output is high
    task automatic wait_high(input bit on_retire, output int cycles, output bit ok);
        string name;
        name   = on_retire ? "retire_valid" : "imem_req_valid";
        cycles = 0;
        ok     = 1'b1;
        @(negedge clk);
        while (!(on_retire ? retire_valid : imem_req_valid)) begin
            if (cycles == TIMEOUT) begin
                $display("timeout: %s never went high within %0d cycles", name, TIMEOUT);
                ok = 1'b0;
                return;
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Serves one fetch from the table, then checks the retire
    task automatic run_row(input int n, output bit ok);
        int stall;
        int lat;
        int wait_cycles;
        stall      = $urandom_range(3, 0);
        lat        = $urandom_range(4, 1);
        row_errors = 0;
        repeat (stall) @(posedge clk);
        @(posedge clk);
        imem_req_ready <= 1'b1;
        wait_high(1'b0, wait_cycles, ok);
        if (!ok) return;
        compare("imem_addr", imem_addr, rows[n].pc);
        @(posedge clk);  // Request accepted
        imem_req_ready <= 1'b0;
        repeat (lat - 1) @(posedge clk);
        imem_resp_valid <= 1'b1;
        imem_resp_data  <= rows[n].inst;
        @(posedge clk);
        imem_resp_valid <= 1'b0;
        wait_high(1'b1, wait_cycles, ok);
        if (!ok) return;
        if (wait_cycles != 0) begin
            $display("retire_valid came %0d cycles late at %0t", wait_cycles, $time);
            row_errors++;
        end
        compare("retire_pc", retire_pc, rows[n].pc);
        compare("retire_rd_we", {31'b0, retire_rd_we}, {31'b0, rows[n].we});
        if (rows[n].we) begin
            compare("retire_rd", {27'b0, retire_rd}, {27'b0, rows[n].rd});
            compare("retire_rd_data", retire_rd_data, rows[n].data);
        end
        compare("retire_next_pc", retire_next_pc, rows[n].npc);
        if (row_errors == 0) begin
            rows_passed++;
        end else begin
            rows_failed++;
        end
        $display("row %0d at %h, ready delay %0d, latency %0d: %s", n, rows[n].pc, stall, lat,
                 (row_errors == 0) ? "pass" : "fail");
    endtask

    initial begin
        int cycles;
        bit ok;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        rows_passed     = 0;
        rows_failed     = 0;
        ok              = 1'b1;
        cycles          = 0;
        void'($urandom(32'hc768a712));
        load_table();
        @(negedge clk);
        while (reset && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (reset) begin
            $display("timeout: reset never went low");
            ok = 1'b0;
        end else if (retire_valid) begin
            $display("mismatch at %0t: retire_valid is high after reset", $time);
            rows_failed++;
        end
        for (int n = 0; n < rows.size() && ok; n++) begin
            run_row(n, ok);
        end
        if (!ok) begin
            rows_failed++;
        end
        $display("%0d rows passed, %0d rows failed", rows_passed, rows_failed);
        if (ok && rows_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
hdl/core_pkg.sv
hdl/decode_if.sv
hdl/alu.sv
hdl/fetch_unit.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/core_top.sv
dv/tb_clock_gen.sv
dv/tb_core.sv

//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps
TOP        := tb_core
FILELIST   := sim.f
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^TB PASSED$$'

clean:
	rm -rf $(OBJ_DIR)
